// ==== src.f ====
hw/ctrl_pkg.sv
hw/wb_slave_port.sv
hw/setting_bank.sv
hw/vita_time.sv
hw/readback_mux.sv
hw/boot_ctrl.sv
hw/umtrx_ctrl_top.sv
tb/umtrx_ctrl_sva.sv
tb/tb_umtrx_ctrl.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the control plane simulation with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   --top-module tb_umtrx_ctrl \
   -f src.f \
   -o tb_umtrx_ctrl

./obj_dir/tb_umtrx_ctrl

// ==== tb/tb_umtrx_ctrl.sv ====
// Control plane testbench
// Random bus traffic against a register model, bootloader reset,
// RAM address swap and VITA time load checks
`timescale 1ns/1ps
`default_nettype none

module tb_umtrx_ctrl import ctrl_pkg::*; ();

   localparam int ACK_TIMEOUT   = 20;
   localparam int RESET_TIMEOUT = 20;

   logic        wb_clk;
   logic        por_rst;
   logic        wb_cyc_i;
   logic        wb_stb_i;
   logic        wb_we_i;
   logic [15:0] wb_adr_i;
   logic [31:0] wb_dat_i;
   logic [31:0] wb_dat_o;
   logic        wb_ack_o;
   logic [15:0] cpu_adr_i;
   logic [15:0] m0_adr_o;
   logic [3:0]  run_i;
   logic        pps_i;
   logic [1:0]  aux_ld_i;
   logic        button_i;
   logic [7:0]  leds_o;
   logic [1:0]  lms_res_o;
   logic        phy_resetn_o;
   logic [1:0]  div_sw_o;

   // Register model
   int          seed;
   logic [7:0]  m_clk;
   logic [7:0]  m_led_sw;
   logic [7:0]  m_led_src;
   logic        m_phy;
   logic [1:0]  m_div;

   umtrx_ctrl_top umtrx_ctrl_top_inst (
      .wb_clk       (wb_clk),
      .por_rst      (por_rst),
      .wb_cyc_i     (wb_cyc_i),
      .wb_stb_i     (wb_stb_i),
      .wb_we_i      (wb_we_i),
      .wb_adr_i     (wb_adr_i),
      .wb_dat_i     (wb_dat_i),
      .wb_dat_o     (wb_dat_o),
      .wb_ack_o     (wb_ack_o),
      .cpu_adr_i    (cpu_adr_i),
      .m0_adr_o     (m0_adr_o),
      .run_i        (run_i),
      .pps_i        (pps_i),
      .aux_ld_i     (aux_ld_i),
      .button_i     (button_i),
      .leds_o       (leds_o),
      .lms_res_o    (lms_res_o),
      .phy_resetn_o (phy_resetn_o),
      .div_sw_o     (div_sw_o)
   );

   initial begin
      wb_clk = 1'b0;
      forever #5 wb_clk = ~wb_clk;
   end

   ////////////////////////////////////////////////////////////
   // Model functions

   // Run status on LEDs 4:1, each LED picked by its source bit
   function automatic logic [7:0] led_mix(input logic [7:0] src, input logic [7:0] sw,
                                          input logic [3:0] run);
      logic [7:0] hw;
      logic [7:0] mix;
      hw      = 8'd0;
      hw[4:1] = run;
      for (int i = 0; i < 8; i++)
         mix[i] = src[i] ? hw[i] : sw[i];
      return mix;
   endfunction

   // Boot RAM and main RAM trade places while the bootloader runs
   function automatic logic [15:0] swap_adr(input logic [15:0] adr);
      if (adr[15] == adr[14])
         return adr ^ BOOT_SWAP_MASK;
      return adr;
   endfunction

   task automatic reset_model();
      m_clk     = 8'd0;
      m_led_sw  = 8'd0;
      m_led_src = LED_SRC_RESET;
      m_phy     = 1'b0;
      m_div     = 2'b11;
   endtask

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("CHECKS FAILED");
      $fatal(1, "simulation stopped at first error");
   endtask

   task automatic compare_value(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
      if (got !== exp)
         abort_run($sformatf("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp));
   endtask

   ////////////////////////////////////////////////////////////
   // Bus master
   task automatic bus_xfer(input logic we, input logic [15:0] adr, input logic [31:0] dat,
                           output logic [31:0] rdat);
      int waited;
      @(posedge wb_clk);
      wb_cyc_i <= 1'b1;
      wb_stb_i <= 1'b1;
      wb_we_i  <= we;
      wb_adr_i <= adr;
      wb_dat_i <= dat;
      waited = 0;
      @(negedge wb_clk);
      while (wb_ack_o !== 1'b1) begin
         if (waited == ACK_TIMEOUT)
            abort_run("bus acknowledge never arrived");
         waited++;
         @(negedge wb_clk);
      end
      compare_value("ack_cycles", 64'(waited), 64'd2);
      rdat = wb_dat_o;
      @(posedge wb_clk);
      wb_cyc_i <= 1'b0;
      wb_stb_i <= 1'b0;
      wb_we_i  <= 1'b0;
   endtask

   // Settings writes are acked with zero data
   task automatic write_setting(input logic [7:0] addr, input logic [31:0] dat);
      logic [31:0] rdat;
      bus_xfer(1'b1, SETTINGS_WIN | {6'd0, addr, 2'b00}, dat, rdat);
      compare_value("wb_dat_o", 64'(rdat), 64'd0);
   endtask

   task automatic read_word(input logic [3:0] idx, output logic [31:0] rdat);
      bus_xfer(1'b0, READBACK_WIN | {10'd0, idx, 2'b00}, 32'd0, rdat);
   endtask

   task automatic compare_outputs();
      @(negedge wb_clk);
      compare_value("leds_o", 64'(leds_o), 64'(led_mix(m_led_src, m_led_sw, run_i)));
      compare_value("lms_res_o", 64'(lms_res_o), 64'(m_clk[6:5]));
      compare_value("phy_resetn_o", 64'(phy_resetn_o), 64'(!m_phy));
      compare_value("div_sw_o", 64'(div_sw_o), 64'(m_div));
   endtask

   // One random register write with a fresh run status
   task automatic random_write();
      logic [31:0] rnd;
      logic [31:0] dat;
      logic [31:0] rdat;
      logic [15:0] adr;
      rnd = $random(seed);
      dat = $random(seed);
      @(posedge wb_clk);
      run_i <= rnd[27:24];
      case (rnd[2:0])
         3'd0: begin
            write_setting(8'(SR_MISC + MISC_CLK), dat);
            m_clk = dat[7:0];
         end
         3'd1: begin
            write_setting(8'(SR_MISC + MISC_LED), dat);
            m_led_sw = dat[7:0];
         end
         3'd2: begin
            write_setting(8'(SR_MISC + MISC_LED_SRC), dat);
            m_led_src = dat[7:0];
         end
         3'd3: begin
            write_setting(8'(SR_MISC + MISC_PHY), dat);
            m_phy = dat[0];
         end
         3'd4: begin
            write_setting(8'(SR_DIVSW), dat);
            m_div[0] = dat[0];
         end
         3'd5: begin
            write_setting(8'(SR_DIVSW + 1), dat);
            m_div[1] = dat[0];
         end
         // Unused settings registers
         3'd6: write_setting(8'd20 + {1'b0, rnd[14:8]}, dat);
         default: begin
            adr = rnd[31:16];
            if (adr[15:12] == 4'h7)
               adr[15] = 1'b1;
            bus_xfer(1'b1, adr, dat, rdat);
         end
      endcase
      compare_outputs();
   endtask

   ////////////////////////////////////////////////////////////
   // Test sequence
   initial begin
      logic [31:0] rnd;
      logic [31:0] rdat;
      logic [31:0] hi;
      logic [31:0] lo;
      logic [31:0] hi2;
      logic [31:0] lo2;
      logic [31:0] lo_armed;
      logic [31:0] pps_hi;
      logic [31:0] pps_lo;
      int          waited;
      seed = 32'h1fabc930;
      por_rst   <= 1'b1;
      wb_cyc_i  <= 1'b0;
      wb_stb_i  <= 1'b0;
      wb_we_i   <= 1'b0;
      wb_adr_i  <= 16'd0;
      wb_dat_i  <= 32'd0;
      cpu_adr_i <= 16'd0;
      run_i     <= 4'd0;
      pps_i     <= 1'b0;
      aux_ld_i  <= 2'd0;
      button_i  <= 1'b0;
      reset_model();
      repeat (5) @(posedge wb_clk);
      por_rst <= 1'b0;
      compare_outputs();
      compare_value("wb_ack_o", 64'(wb_ack_o), 64'd0);

      read_word(RB_COMPAT, rdat);
      compare_value("compat", 64'(rdat), 64'h0009_0000);
      repeat (4) begin
         rnd = $random(seed);
         @(posedge wb_clk);
         aux_ld_i <= rnd[1:0];
         button_i <= rnd[2];
         read_word(RB_IO, rdat);
         compare_value("io_word", 64'(rdat), 64'({13'd0, rnd[1:0], rnd[2], 16'd0}));
      end

      repeat (60) random_write();

      // Swap is active until the bootloader reports done
      repeat (16) begin
         rnd = $random(seed);
         @(posedge wb_clk);
         cpu_adr_i <= rnd[15:0];
         @(negedge wb_clk);
         compare_value("m0_adr_o", 64'(m0_adr_o), 64'(swap_adr(rnd[15:0])));
      end
      write_setting(8'(SR_MISC + MISC_CLK), 32'hFF);
      write_setting(8'(SR_MISC + MISC_PHY), 32'h1);
      write_setting(8'(SR_DIVSW), 32'h0);
      m_clk    = 8'hFF;
      m_phy    = 1'b1;
      m_div[0] = 1'b0;
      compare_outputs();
      write_setting(8'(SR_MISC + MISC_BLDR), 32'h1);
      waited = 0;
      @(negedge wb_clk);
      while (div_sw_o !== 2'b11) begin
         if (waited == RESET_TIMEOUT)
            abort_run("bootloader done did not reset the registers");
         waited++;
         @(negedge wb_clk);
      end
      reset_model();
      compare_outputs();
      repeat (16) begin
         rnd = $random(seed);
         @(posedge wb_clk);
         cpu_adr_i <= rnd[15:0];
         @(negedge wb_clk);
         compare_value("m0_adr_o", 64'(m0_adr_o), 64'(rnd[15:0]));
      end
      repeat (10) random_write();

      ////////////////////////////////////////////////////////////
      // VITA time, load now
      hi = $random(seed);
      lo = $random(seed);
      lo[31] = 1'b0;
      write_setting(8'(SR_TIME64 + TIME_HI), hi);
      write_setting(8'(SR_TIME64 + TIME_LO), lo);
      write_setting(8'(SR_TIME64 + TIME_CTRL), 32'd1);
      read_word(RB_TIME_HI, rdat);
      compare_value("time_hi", 64'(rdat), 64'(hi));
      read_word(RB_TIME_LO, rdat);
      if (rdat < lo || rdat > lo + 32'd64)
         abort_run($sformatf("time low word 0x%0h is not within 64 of 0x%0h", rdat, lo));

      // Load at the next PPS edge
      hi2 = $random(seed);
      if (hi2 == hi)
         hi2 = ~hi;
      lo2 = $random(seed);
      lo2[31] = 1'b0;
      write_setting(8'(SR_TIME64 + TIME_HI), hi2);
      write_setting(8'(SR_TIME64 + TIME_LO), lo2);
      write_setting(8'(SR_TIME64 + TIME_CTRL), 32'd0);
      rnd = $random(seed);
      repeat (8 + rnd[3:0]) @(posedge wb_clk);
      read_word(RB_TIME_HI, rdat);
      compare_value("time_hi_armed", 64'(rdat), 64'(hi));
      read_word(RB_TIME_LO, lo_armed);
      @(posedge wb_clk);
      pps_i <= 1'b1;
      // Two synchronizer flops, edge detect, then the load
      repeat (4) @(posedge wb_clk);
      pps_i <= 1'b0;
      read_word(RB_TIME_HI, rdat);
      compare_value("time_hi_pps", 64'(rdat), 64'(hi2));
      read_word(RB_TIME_LO, rdat);
      if (rdat < lo2 || rdat > lo2 + 32'd64)
         abort_run($sformatf("time low word 0x%0h is not within 64 of 0x%0h", rdat, lo2));
      read_word(RB_PPS_HI, pps_hi);
      read_word(RB_PPS_LO, pps_lo);
      read_word(RB_PPS_HI, rdat);
      compare_value("pps_hi_repeat", 64'(rdat), 64'(pps_hi));
      read_word(RB_PPS_LO, rdat);
      compare_value("pps_lo_repeat", 64'(rdat), 64'(pps_lo));
      // Captured before the load, still in the load-now epoch
      compare_value("pps_hi", 64'(pps_hi), 64'(hi));
      // A few cycles after the armed read of the low word
      if (pps_lo < lo_armed || pps_lo > lo_armed + 32'd64)
         abort_run($sformatf("PPS low word 0x%0h is not within 64 of 0x%0h", pps_lo, lo_armed));

      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== tb/umtrx_ctrl_sva.sv ====
// Control plane bus and LED assertions
// Bound into the readback mux and the settings bank
`timescale 1ns/1ps
`default_nettype none

module umtrx_ctrl_sva (
   input wire logic       wb_clk,
   input wire logic       rst_i,
   input wire logic       rb_vld_i,
   input wire logic       ack_i,
   input wire logic [3:0] run_i,
   input wire logic [7:0] led_src_i,
   input wire logic [7:0] led_sw_i,
   input wire logic [7:0] leds_i
);

   // Ack is a single pulse, one cycle after the registered request
   ack_single: assert property (@(posedge wb_clk) disable iff (rst_i) ack_i |=> !ack_i)
      else $error("acknowledge held for more than one cycle");
   ack_follows_req: assert property (@(posedge wb_clk) disable iff (rst_i) rb_vld_i |=> ack_i)
      else $error("accepted request was not acknowledged on time");
   ack_has_req: assert property (@(posedge wb_clk) disable iff (rst_i) ack_i |-> $past(rb_vld_i))
      else $error("acknowledge without an accepted request");

   ////////////////////////////////////////////////////////////
   // LED mux
   leds_mux: assert property (@(posedge wb_clk) disable iff (rst_i)
      leds_i == ((led_src_i & {3'b000, run_i, 1'b0}) | (~led_src_i & led_sw_i)))
      else $error("LED output does not follow the source mask");

endmodule

bind readback_mux umtrx_ctrl_sva readback_sva_inst (
   .wb_clk (wb_clk), .rst_i (wb_rst_i), .rb_vld_i (rb_vld_i), .ack_i (wb_ack_o),
   .run_i (4'd0), .led_src_i (8'd0), .led_sw_i (8'd0), .leds_i (8'd0)
);

bind setting_bank umtrx_ctrl_sva setting_sva_inst (
   .wb_clk (wb_clk), .rst_i (wb_rst_i), .rb_vld_i (1'b0), .ack_i (1'b0),
   .run_i (run_i), .led_src_i (led_src), .led_sw_i (led_sw), .leds_i (leds_o)
);

`default_nettype wire

// ==== hw/umtrx_ctrl_top.sv ====
// Radio core control plane top level
// Bus slave port, settings bank, VITA time, readback and the
// bootloader reset controller, all on wb_clk
`timescale 1ns/1ps
`default_nettype none

module umtrx_ctrl_top import ctrl_pkg::*; #(
   parameter int SR_MISC   = ctrl_pkg::SR_MISC,
   parameter int SR_TIME64 = ctrl_pkg::SR_TIME64,
   parameter int SR_DIVSW  = ctrl_pkg::SR_DIVSW
) (
   input  wire logic        wb_clk,
   input  wire logic        por_rst,
   // Wishbone slave
   input  wire logic        wb_cyc_i,
   input  wire logic        wb_stb_i,
   input  wire logic        wb_we_i,
   input  wire logic [15:0] wb_adr_i,
   input  wire logic [31:0] wb_dat_i,
   output logic [31:0]      wb_dat_o,
   output logic             wb_ack_o,
   // Processor address path
   input  wire logic [15:0] cpu_adr_i,
   output logic [15:0]      m0_adr_o,
   // Status and control pins
   input  wire logic [3:0]  run_i,
   input  wire logic        pps_i,
   input  wire logic [1:0]  aux_ld_i,
   input  wire logic        button_i,
   output logic [7:0]       leds_o,
   output logic [1:0]       lms_res_o,
   output logic             phy_resetn_o,
   output logic [1:0]       div_sw_o
);

   logic        wb_rst;
   logic        bldr_done;
   set_bus_t    set_bus;
   logic [3:0]  rb_idx;
   logic        rb_vld;
   vita_times_t vita_times;

   boot_ctrl boot_ctrl_inst (
      .wb_clk      (wb_clk),
      .por_rst     (por_rst),
      .bldr_done_i (bldr_done),
      .cpu_adr_i   (cpu_adr_i),
      .wb_rst_o    (wb_rst),
      .m0_adr_o    (m0_adr_o)
   );

   ////////////////////////////////////////////////////////////
   // Stage one
   wb_slave_port wb_slave_port_inst (
      .wb_clk   (wb_clk),
      .wb_rst_i (wb_rst),
      .wb_cyc_i (wb_cyc_i),
      .wb_stb_i (wb_stb_i),
      .wb_we_i  (wb_we_i),
      .wb_adr_i (wb_adr_i),
      .wb_dat_i (wb_dat_i),
      .wb_ack_i (wb_ack_o),
      .set_o    (set_bus),
      .rb_idx_o (rb_idx),
      .rb_vld_o (rb_vld)
   );

   ////////////////////////////////////////////////////////////
   // Stage two
   setting_bank #(
      .MISC_BASE  (SR_MISC),
      .DIVSW_BASE (SR_DIVSW)
   ) setting_bank_inst (
      .wb_clk       (wb_clk),
      .wb_rst_i     (wb_rst),
      .set_i        (set_bus),
      .run_i        (run_i),
      .leds_o       (leds_o),
      .lms_res_o    (lms_res_o),
      .phy_resetn_o (phy_resetn_o),
      .div_sw_o     (div_sw_o),
      .bldr_done_o  (bldr_done)
   );

   vita_time #(
      .TIME_BASE (SR_TIME64)
   ) vita_time_inst (
      .wb_clk   (wb_clk),
      .wb_rst_i (wb_rst),
      .set_i    (set_bus),
      .pps_i    (pps_i),
      .times_o  (vita_times)
   );

   ////////////////////////////////////////////////////////////
   // Stage three
   readback_mux readback_mux_inst (
      .wb_clk   (wb_clk),
      .wb_rst_i (wb_rst),
      .rb_idx_i (rb_idx),
      .rb_vld_i (rb_vld),
      .times_i  (vita_times),
      .aux_ld_i (aux_ld_i),
      .button_i (button_i),
      .wb_dat_o (wb_dat_o),
      .wb_ack_o (wb_ack_o)
   );

endmodule

`default_nettype wire

// ==== hw/boot_ctrl.sv ====
// Bootloader reset controller
// Issues one internal reset when the bootloader finishes and swaps
// boot RAM and main RAM addresses while it runs
`timescale 1ns/1ps
`default_nettype none

module boot_ctrl import ctrl_pkg::*; (
   input  wire logic        wb_clk,
   input  wire logic        por_rst,
   input  wire logic        bldr_done_i,
   input  wire logic [15:0] cpu_adr_i,
   output logic             wb_rst_o,
   output logic [15:0]      m0_adr_o
);

   typedef enum logic {
      BLDR_WAIT = 1'b0,
      BLDR_DONE = 1'b1
   } bldr_state_t;

   bldr_state_t state;

   always_ff @(posedge wb_clk) begin
      if (por_rst) begin
         state    <= BLDR_WAIT;
         wb_rst_o <= 1'b1;
      end else begin
         case (state)
            BLDR_WAIT: begin
               wb_rst_o <= bldr_done_i;
               if (bldr_done_i)
                  state <= BLDR_DONE;
            end
            // Stays here until the next power-on reset
            default: begin
               wb_rst_o <= 1'b0;
            end
         endcase
      end
   end

   ////////////////////////////////////////////////////////////
   // Address swap, only boot RAM and main RAM regions move
   always_comb begin
      if (state == BLDR_WAIT && cpu_adr_i[15] == cpu_adr_i[14])
         m0_adr_o = cpu_adr_i ^ BOOT_SWAP_MASK;
      else
         m0_adr_o = cpu_adr_i;
   end

endmodule

`default_nettype wire

// ==== hw/readback_mux.sv ====
// Readback word select
// Registers the selected status word together with the bus ack
`timescale 1ns/1ps
`default_nettype none

module readback_mux import ctrl_pkg::*; (
   input  wire logic        wb_clk,
   input  wire logic        wb_rst_i,
   input  wire logic [3:0]  rb_idx_i,
   input  wire logic        rb_vld_i,
   input  wire vita_times_t times_i,
   input  wire logic [1:0]  aux_ld_i,
   input  wire logic        button_i,
   output logic [31:0]      wb_dat_o,
   output logic             wb_ack_o
);

   logic [31:0] rb_word;

   always_comb begin
      case (rb_idx_i)
         RB_TIME_HI: rb_word = times_i.now[63:32];
         RB_TIME_LO: rb_word = times_i.now[31:0];
         RB_COMPAT:  rb_word = COMPAT_NUM;
         RB_IO:      rb_word = {13'd0, aux_ld_i, button_i, 16'd0};
         RB_PPS_HI:  rb_word = times_i.pps[63:32];
         RB_PPS_LO:  rb_word = times_i.pps[31:0];
         // Router status and empty slots
         default:    rb_word = 32'd0;
      endcase
   end

   always_ff @(posedge wb_clk) begin
      if (wb_rst_i) begin
         wb_ack_o <= 1'b0;
      end else begin
         wb_ack_o <= rb_vld_i;
      end
   end

   always_ff @(posedge wb_clk) begin
      if (rb_vld_i)
         wb_dat_o <= rb_word;
   end

endmodule

`default_nettype wire

// ==== hw/vita_time.sv ====
// VITA 64-bit time counter
// Free-running count of wb_clk cycles, loadable now or at the
// next PPS edge, with the time captured at every PPS edge
`timescale 1ns/1ps
`default_nettype none

module vita_time import ctrl_pkg::*; #(
   parameter int TIME_BASE = 10
) (
   input  wire logic     wb_clk,
   input  wire logic     wb_rst_i,
   input  wire set_bus_t set_i,
   input  wire logic     pps_i,
   output vita_times_t   times_o
);

   localparam logic [7:0] A_HI   = 8'(TIME_BASE + TIME_HI);
   localparam logic [7:0] A_LO   = 8'(TIME_BASE + TIME_LO);
   localparam logic [7:0] A_CTRL = 8'(TIME_BASE + TIME_CTRL);

   logic [31:0] pend_hi;
   logic [31:0] pend_lo;
   logic [63:0] vt_now;
   logic [63:0] vt_pps;
   logic        armed;
   logic        load_now;
   logic        arm_pps;
   logic        pps_s1;
   logic        pps_s2;
   logic        pps_d;
   logic        pps_edge;

   assign load_now = set_i.stb && set_i.addr == A_CTRL && set_i.data[0];
   assign arm_pps  = set_i.stb && set_i.addr == A_CTRL && !set_i.data[0];

   // Pending load value
   always_ff @(posedge wb_clk) begin
      if (set_i.stb && set_i.addr == A_HI)
         pend_hi <= set_i.data;
      if (set_i.stb && set_i.addr == A_LO)
         pend_lo <= set_i.data;
   end

   ////////////////////////////////////////////////////////////
   // PPS synchronizer and rising edge detect
   always_ff @(posedge wb_clk) begin
      if (wb_rst_i) begin
         pps_s1 <= 1'b0;
         pps_s2 <= 1'b0;
         pps_d  <= 1'b0;
      end else begin
         pps_s1 <= pps_i;
         pps_s2 <= pps_s1;
         pps_d  <= pps_s2;
      end
   end

   assign pps_edge = pps_s2 & ~pps_d;

   ////////////////////////////////////////////////////////////
   // Counter, load and capture
   always_ff @(posedge wb_clk) begin
      if (wb_rst_i) begin
         vt_now <= 64'd0;
         vt_pps <= 64'd0;
         armed  <= 1'b0;
      end else begin
         if (load_now) begin
            vt_now <= {pend_hi, pend_lo};
         end else if (pps_edge && armed) begin
            vt_now <= {pend_hi, pend_lo};
         end else begin
            vt_now <= vt_now + 64'd1;
         end
         if (pps_edge) begin
            vt_pps <= vt_now;
         end
         // An armed load is consumed by the edge it waits for
         if (arm_pps)
            armed <= 1'b1;
         else if (pps_edge)
            armed <= 1'b0;
      end
   end

   assign times_o.now = vt_now;
   assign times_o.pps = vt_pps;

endmodule

`default_nettype wire

// ==== hw/setting_bank.sv ====
// Misc settings register bank
// Clock outputs, LEDs, PHY reset, bootloader done and diversity
// switches, plus the LED mux between run status and software
`timescale 1ns/1ps
`default_nettype none

module setting_bank import ctrl_pkg::*; #(
   parameter int MISC_BASE  = 0,
   parameter int DIVSW_BASE = 180
) (
   input  wire logic       wb_clk,
   input  wire logic       wb_rst_i,
   input  wire set_bus_t   set_i,
   input  wire logic [3:0] run_i,
   output logic [7:0]      leds_o,
   output logic [1:0]      lms_res_o,
   output logic            phy_resetn_o,
   output logic [1:0]      div_sw_o,
   output logic            bldr_done_o
);

   localparam logic [7:0] A_CLK     = 8'(MISC_BASE + MISC_CLK);
   localparam logic [7:0] A_LED     = 8'(MISC_BASE + MISC_LED);
   localparam logic [7:0] A_PHY     = 8'(MISC_BASE + MISC_PHY);
   localparam logic [7:0] A_BLDR    = 8'(MISC_BASE + MISC_BLDR);
   localparam logic [7:0] A_LED_SRC = 8'(MISC_BASE + MISC_LED_SRC);
   localparam logic [7:0] A_DIVSW1  = 8'(DIVSW_BASE);
   localparam logic [7:0] A_DIVSW2  = 8'(DIVSW_BASE + 1);

   logic [7:0] clock_outs;
   logic [7:0] led_sw;
   logic [7:0] led_src;
   logic [7:0] led_hw;
   logic       phy_reset;
   logic       bldr_done;
   logic [1:0] div_sw;

   ////////////////////////////////////////////////////////////
   // Register writes
   always_ff @(posedge wb_clk) begin
      if (wb_rst_i) begin
         clock_outs <= 8'd0;
         led_sw     <= 8'd0;
         led_src    <= LED_SRC_RESET;
         phy_reset  <= 1'b0;
         bldr_done  <= 1'b0;
         div_sw     <= 2'b11;
      end else if (set_i.stb) begin
         case (set_i.addr)
            A_CLK:     clock_outs <= set_i.data[7:0];
            A_LED:     led_sw     <= set_i.data[7:0];
            A_PHY:     phy_reset  <= set_i.data[0];
            A_BLDR:    bldr_done  <= set_i.data[0];
            A_LED_SRC: led_src    <= set_i.data[7:0];
            A_DIVSW1:  div_sw[0]  <= set_i.data[0];
            A_DIVSW2:  div_sw[1]  <= set_i.data[0];
            default:   ;
         endcase
      end
   end

   ////////////////////////////////////////////////////////////
   // LED mux, source bit 1 selects hardware status
   assign led_hw = {3'b000, run_i, 1'b0};
   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

   // LMS reset pins ride on the clock output register
   assign lms_res_o    = clock_outs[6:5];
   assign phy_resetn_o = ~phy_reset;
   assign div_sw_o     = div_sw;
   assign bldr_done_o  = bldr_done;

endmodule

`default_nettype wire

// ==== hw/wb_slave_port.sv ====
// Wishbone slave port
// Registers one request at a time and decodes it into either a
// settings bus write or a readback index with a valid pulse
`timescale 1ns/1ps
`default_nettype none

module wb_slave_port import ctrl_pkg::*; (
   input  wire logic        wb_clk,
   input  wire logic        wb_rst_i,
   input  wire logic        wb_cyc_i,
   input  wire logic        wb_stb_i,
   input  wire logic        wb_we_i,
   input  wire logic [15:0] wb_adr_i,
   input  wire logic [31:0] wb_dat_i,
   input  wire logic        wb_ack_i,
   output set_bus_t         set_o,
   output logic [3:0]       rb_idx_o,
   output logic             rb_vld_o
);

   wb_req_t req;
   logic    req_vld;
   logic    accept;
   logic    in_settings;
   logic    in_readback;
   logic    set_write;

   // Blocked while the request is in flight and while ack is out
   assign accept = wb_cyc_i & wb_stb_i & ~wb_ack_i & ~req_vld;

   always_ff @(posedge wb_clk) begin
      if (wb_rst_i) begin
         req_vld <= 1'b0;
      end else begin
         req_vld <= accept;
      end
   end

   // Request payload
   always_ff @(posedge wb_clk) begin
      if (accept) begin
         req.adr <= wb_adr_i;
         req.dat <= wb_dat_i;
         req.we  <= wb_we_i;
      end
   end

   ////////////////////////////////////////////////////////////
   // Window decode
   assign in_settings = (req.adr & SETTINGS_MASK) == SETTINGS_WIN;
   assign in_readback = (req.adr & READBACK_MASK) == READBACK_WIN;
   assign set_write   = req.we & in_settings;

   always_comb begin
      set_o.stb  = req_vld & set_write;
      set_o.addr = req.adr[9:2];
      set_o.data = req.dat;
   end

   // Every request gets acked, settings writes read back zero
   assign rb_vld_o = req_vld;
   assign rb_idx_o = in_readback ? req.adr[5:2] : 4'd0;

endmodule

`default_nettype wire

// ==== hw/ctrl_pkg.sv ====
// Control plane shared definitions
// Bus request, settings bus and VITA time types, register map
// offsets, address windows and the compatibility number
`default_nettype none

package ctrl_pkg;

   ////////////////////////////////////////////////////////////
   // Bus and payload types
   typedef struct packed {
      logic [15:0] adr;
      logic [31:0] dat;
      logic        we;
   } wb_req_t;

   typedef struct packed {
      logic        stb;
      logic [7:0]  addr;
      logic [31:0] data;
   } set_bus_t;

   typedef struct packed {
      logic [63:0] now;
      logic [63:0] pps;
   } vita_times_t;

   ////////////////////////////////////////////////////////////
   // Address windows on the 16-bit byte address
   localparam logic [15:0] SETTINGS_WIN  = 16'h7000;
   localparam logic [15:0] SETTINGS_MASK = 16'hF000;
   localparam logic [15:0] READBACK_WIN  = 16'h5C00;
   localparam logic [15:0] READBACK_MASK = 16'hFC00;

   // Settings register bases
   localparam int SR_MISC   = 0;
   localparam int SR_TIME64 = 10;
   localparam int SR_DIVSW  = 180;

   // Offsets inside the misc block
   localparam int MISC_CLK     = 0;
   localparam int MISC_LED     = 3;
   localparam int MISC_PHY     = 4;
   localparam int MISC_BLDR    = 5;
   localparam int MISC_LED_SRC = 6;

   // Offsets inside the time block
   localparam int TIME_HI   = 0;
   localparam int TIME_LO   = 1;
   localparam int TIME_CTRL = 2;

   // Readback word indices
   localparam logic [3:0] RB_TIME_HI = 4'd10;
   localparam logic [3:0] RB_TIME_LO = 4'd11;
   localparam logic [3:0] RB_COMPAT  = 4'd12;
   localparam logic [3:0] RB_IO      = 4'd13;
   localparam logic [3:0] RB_PPS_HI  = 4'd14;
   localparam logic [3:0] RB_PPS_LO  = 4'd15;

   // Major in the upper half, minor in the lower half
   localparam logic [31:0] COMPAT_NUM = {16'd9, 16'd0};

   localparam logic [7:0]  LED_SRC_RESET  = 8'h1E;
   localparam logic [15:0] BOOT_SWAP_MASK = 16'hC000;

endpackage

`default_nettype wire
